/* rtl/read_datapath_params.svh */
// Sizes assume two x8 DQS groups at half rate, with RD_FIFO_AW and RD_LAT_CNT_W wide enough for depth and latency
`ifndef READ_DATAPATH_PARAMS_SVH
`define READ_DATAPATH_PARAMS_SVH

// **************************************************
// Interface geometry
// **************************************************
// Number of read DQS groups on the interface
`define RD_NUM_GROUPS 2
// DQ pins behind each DQS strobe
`define RD_GROUP_DQ 8
// Four beats per AFI cycle at half rate with DDR capture
`define RD_TIMESLOTS 4
// AFI phases per AFI clock
`define RD_RATE_RATIO 2

// **************************************************
// Read FIFO, latency and OCT window
// **************************************************
`define RD_FIFO_DEPTH 8
`define RD_FIFO_AW 3
// Longest read latency the history register can reach, in AFI cycles
`define RD_MAX_LATENCY 16
`define RD_LAT_CNT_W 5
// OCT stays enabled from this history tap through the last tap
`define RD_OCT_ON_DELAY 1
`define RD_OCT_OFF_DELAY 6
`endif

/* rtl/read_datapath_pkg.sv */
// Struct field order fixes the bit order on every port, so anything driving these buses packs them the same way
`default_nettype none
`include "read_datapath_params.svh"

package read_datapath_pkg;

	// One group's DQ bits for a single time slot
	typedef logic [`RD_GROUP_DQ-1:0] dq_beat_t;

	// All beats of one group for one AFI cycle
	// Slot 0 is the earliest beat and sits in the low bits
	typedef struct packed {
		dq_beat_t [`RD_TIMESLOTS-1:0] beat;
	} group_word_t;

	// Data coming out of the capture registers, already on the AFI clock
	// A strobe bit marks a cycle that carries a new word for its group
	typedef struct packed {
		logic [`RD_NUM_GROUPS-1:0] strobe;
		group_word_t [`RD_NUM_GROUPS-1:0] word;
	} ddio_capture_t;

	// Read request from the controller, one bit per AFI phase
	typedef struct packed {
		logic [`RD_RATE_RATIO-1:0] rdata_en;
		logic [`RD_RATE_RATIO-1:0] rdata_en_full;
	} afi_read_req_t;

	// AFI order is time slot outermost and group inside it
	typedef dq_beat_t [`RD_TIMESLOTS-1:0][`RD_NUM_GROUPS-1:0] afi_rdata_t;
	// Sequencer order keeps each group's slots next to each other
	typedef dq_beat_t [`RD_NUM_GROUPS-1:0][`RD_TIMESLOTS-1:0] seq_rdata_t;

	typedef logic [`RD_LAT_CNT_W-1:0] lat_cnt_t;

endpackage

`default_nettype wire

/* rtl/read_enable_timing.sv */
// Latency counts above RD_MAX_LATENCY are clamped, and only phase 0 of each request is tracked
`timescale 1ns/1ns
`default_nettype none
`include "read_datapath_params.svh"

module read_enable_timing
	import read_datapath_pkg::*;
(
	input  wire                       pll_afi_clk,
	input  wire                       reset_n_afi_clk,
	input  wire afi_read_req_t        read_req_i,
	input  wire lat_cnt_t             latency_i,
	output logic                      read_enable_o,
	output logic [`RD_RATE_RATIO-1:0] read_valid_o,
	output logic                      force_oct_off_o
);

	// History of past requests, bit k holds the request sampled k+1 edges ago
	logic [`RD_MAX_LATENCY-1:0] en_hist;
	logic [`RD_MAX_LATENCY-1:0] full_hist;
	// Tap k is the request sampled k edges before the current one, tap 0 is the live input
	logic [`RD_MAX_LATENCY:0]   en_taps;
	logic [`RD_MAX_LATENCY:0]   full_taps;
	lat_cnt_t                   lat_sel;

	// **************************************************
	// Request history
	// **************************************************
	// At half rate the controller raises both phases together, so phase 0 stands for the pair
	assign en_taps   = {en_hist, read_req_i.rdata_en[0]};
	assign full_taps = {full_hist, read_req_i.rdata_en_full[0]};

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist   <= '0;
			full_hist <= '0;
		end
		else
		begin
			// Shifting by one keeps the low taps and drops the oldest bit
			en_hist   <= en_taps[`RD_MAX_LATENCY-1:0];
			full_hist <= full_taps[`RD_MAX_LATENCY-1:0];
		end
	end

	// **************************************************
	// Latency selection
	// **************************************************
	// Out of range counts would index past the last tap
	always_comb
	begin
		if (latency_i > lat_cnt_t'(`RD_MAX_LATENCY))
			lat_sel = lat_cnt_t'(`RD_MAX_LATENCY);
		else
			lat_sel = latency_i;
	end

	// A request sampled at t appears on tap L at edge t+L, so both strobes are high in cycle t+L
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_enable_o   <= 1'b0;
			read_valid_o    <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			read_enable_o <= full_taps[lat_sel];
			read_valid_o  <= {`RD_RATE_RATIO{en_taps[lat_sel]}};
			// OCT is forced off unless a full request lies inside the on window
			force_oct_off_o <= ~(|full_taps[`RD_OCT_OFF_DELAY:`RD_OCT_ON_DELAY]);
		end
	end

endmodule

`default_nettype wire

/* rtl/read_group_fifo.sv */
// No full or empty flags exist, so the controller must never leave more than RD_FIFO_DEPTH words unread
`timescale 1ns/1ns
`default_nettype none
`include "read_datapath_params.svh"

module read_group_fifo
	import read_datapath_pkg::*;
(
	input  wire              pll_afi_clk,
	input  wire              reset_n_afi_clk,
	input  wire              wr_strobe_i,
	input  wire group_word_t wr_word_i,
	input  wire              seq_fifo_reset_i,
	input  wire              read_enable_i,
	output group_word_t      rd_word_o
);

	typedef logic [`RD_FIFO_AW-1:0] ptr_t;

	localparam ptr_t LAST_ENTRY = ptr_t'(`RD_FIFO_DEPTH - 1);

	group_word_t mem [`RD_FIFO_DEPTH];
	ptr_t        wr_ptr;
	ptr_t        rd_ptr;

	// Wraps at the last entry, so depths that are not a power of two also work
	function automatic ptr_t next_ptr(input ptr_t ptr);
		return (ptr == LAST_ENTRY) ? '0 : ptr_t'(ptr + 1'b1);
	endfunction

	// **************************************************
	// Pointers
	// **************************************************
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (seq_fifo_reset_i)
		begin
			// Sequencer flush drops every unread word of this group
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_strobe_i)
				wr_ptr <= next_ptr(wr_ptr);
			if (read_enable_i)
				rd_ptr <= next_ptr(rd_ptr);
		end
	end

	// **************************************************
	// Storage and output register
	// **************************************************
	// A read and a write to the same entry in one cycle return the old word
	always_ff @(posedge pll_afi_clk)
	begin
		if (wr_strobe_i && !seq_fifo_reset_i)
			mem[wr_ptr] <= wr_word_i;
		// Output holds its last word between reads
		if (read_enable_i)
			rd_word_o <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

/* rtl/read_result_merge.sv */
// Group words are taken as already aligned, since all groups share one read enable
`timescale 1ns/1ns
`default_nettype none
`include "read_datapath_params.svh"

module read_result_merge
	import read_datapath_pkg::*;
(
	input  wire                                   pll_afi_clk,
	input  wire                                   reset_n_afi_clk,
	input  wire [`RD_RATE_RATIO-1:0]              read_valid_i,
	input  wire group_word_t [`RD_NUM_GROUPS-1:0] group_words_i,
	output afi_rdata_t                            afi_rdata_o,
	output seq_rdata_t                            phy_mux_read_fifo_q_o,
	output logic [`RD_RATE_RATIO-1:0]             afi_rdata_valid_o
);

	// **************************************************
	// Valid strobe
	// **************************************************
	// The FIFO output register lags the read enable by one cycle
	// One register stage here puts the valid on the same cycle as the data
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			afi_rdata_valid_o <= '0;
		else
			afi_rdata_valid_o <= read_valid_i;
	end

	// **************************************************
	// Data orderings
	// **************************************************
	// For two groups the AFI bus reads D1_T3 D0_T3 ... D1_T0 D0_T0 from the top down
	// The sequencer bus reads D1_T3 ... D1_T0 D0_T3 ... D0_T0 from the top down
	for (genvar g = 0; g < `RD_NUM_GROUPS; g++)
	begin : g_group
		for (genvar t = 0; t < `RD_TIMESLOTS; t++)
		begin : g_slot
			// Same beat lands in both buses, only its position differs
			assign afi_rdata_o[t][g]           = group_words_i[g].beat[t];
			assign phy_mux_read_fifo_q_o[g][t] = group_words_i[g].beat[t];
		end
	end

endmodule

`default_nettype wire

/* rtl/read_datapath_top.sv */
// Capture data must already be on pll_afi_clk, and data and valid follow a request by latency plus one
`timescale 1ns/1ns
`default_nettype none
`include "read_datapath_params.svh"

module read_datapath_top
	import read_datapath_pkg::*;
(
	input  wire                       pll_afi_clk,
	input  wire                       reset_n_afi_clk,
	input  wire afi_read_req_t        afi_read_req_i,
	input  wire ddio_capture_t        ddio_capture_i,
	input  wire lat_cnt_t             seq_read_latency_counter_i,
	input  wire [`RD_NUM_GROUPS-1:0]  seq_read_fifo_reset_i,
	output afi_rdata_t                afi_rdata_o,
	output seq_rdata_t                phy_mux_read_fifo_q_o,
	output logic [`RD_RATE_RATIO-1:0] afi_rdata_valid_o,
	output logic                      force_oct_off_o
);

	// One read enable pops every group at once
	logic                             read_enable;
	logic [`RD_RATE_RATIO-1:0]        read_valid;
	group_word_t [`RD_NUM_GROUPS-1:0] group_words;

	// **************************************************
	// Latency and OCT timing
	// **************************************************
	read_enable_timing u_read_enable_timing (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.read_req_i      (afi_read_req_i),
		.latency_i       (seq_read_latency_counter_i),
		.read_enable_o   (read_enable),
		.read_valid_o    (read_valid),
		.force_oct_off_o (force_oct_off_o)
	);

	// Each group has its own FIFO and its own sequencer flush
	for (genvar g = 0; g < `RD_NUM_GROUPS; g++)
	begin : g_fifo
		read_group_fifo u_read_group_fifo (
			.pll_afi_clk      (pll_afi_clk),
			.reset_n_afi_clk  (reset_n_afi_clk),
			.wr_strobe_i      (ddio_capture_i.strobe[g]),
			.wr_word_i        (ddio_capture_i.word[g]),
			.seq_fifo_reset_i (seq_read_fifo_reset_i[g]),
			.read_enable_i    (read_enable),
			.rd_word_o        (group_words[g])
		);
	end

	// Valid register and both output orderings
	read_result_merge u_read_result_merge (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.read_valid_i          (read_valid),
		.group_words_i         (group_words),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o)
	);

endmodule

`default_nettype wire

/* dv/read_datapath_checker.sv */
// Bound into read_enable_timing, its latency rules cover counts from 1 to RD_MAX_LATENCY only
`timescale 1ns/1ns
`default_nettype none
`include "read_datapath_params.svh"

module read_datapath_checker
	import read_datapath_pkg::*;
(
	input wire                      pll_afi_clk,
	input wire                      reset_n_afi_clk,
	input wire afi_read_req_t       read_req_i,
	input wire lat_cnt_t            latency_i,
	input wire                      read_enable_o,
	input wire [`RD_RATE_RATIO-1:0] read_valid_o,
	input wire                      force_oct_off_o
);

	// Count of failed assertions
	int unsigned fail_cnt = 0;
	// Active edges since reset release, saturating once the deepest tap holds real history
	int unsigned run_cnt;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			run_cnt <= 0;
		else if (run_cnt <= `RD_MAX_LATENCY)
			run_cnt <= run_cnt + 1;
	end

	// **************************************************
	// Latency tap rules
	// **************************************************
	// A request sampled at t shows up on the strobes after edge t+L
	// Seen from the next edge that is the request input L+1 edges back
	for (genvar l = 1; l <= `RD_MAX_LATENCY; l++)
	begin : g_lat
		assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			(run_cnt > l && $past(latency_i) == lat_cnt_t'(l)) |->
			read_valid_o == {`RD_RATE_RATIO{$past(read_req_i.rdata_en[0], l + 1)}})
			else
			begin
				fail_cnt++;
				$error("read_valid does not follow rdata_en at latency %0d", l);
			end

		// The FIFO read enable follows rdata_en_full the same way
		assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			(run_cnt > l && $past(latency_i) == lat_cnt_t'(l)) |->
			read_enable_o == $past(read_req_i.rdata_en_full[0], l + 1))
			else
			begin
				fail_cnt++;
				$error("read_enable does not follow rdata_en_full at latency %0d", l);
			end
	end

	// **************************************************
	// Reset rule
	// **************************************************
	assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> (!read_enable_o && read_valid_o == '0 && !force_oct_off_o))
		else
		begin
			fail_cnt++;
			$error("timing outputs are not cleared while reset is asserted");
		end

endmodule

bind read_enable_timing read_datapath_checker u_read_datapath_checker (.*);

`default_nettype wire

/* dv/read_datapath_tb.sv */
// Needs fewer than 1024 post-reset cycles for its history model, and keeps every burst at or below the FIFO depth
`timescale 1ns/1ns
`default_nettype none
`include "read_datapath_params.svh"

module read_datapath_tb
	import read_datapath_pkg::*;
();

	localparam int MAX_EDGES = 1024;
	localparam int NUM_TESTS = 6;

	typedef struct {
		string name;
		int    lat;
		int    words;
		int    delay;
		bit    flush;
	} test_t;

	// Latency, burst length, capture-to-request gap and sequencer flush for each case
	test_t tests [NUM_TESTS] = '{
		'{"lat1", 1, 1, 0, 1'b0},
		'{"lat5", 5, 1, 3, 1'b0},
		'{"lat16", 16, 1, 0, 1'b0},
		'{"burst8", 3, 8, 1, 1'b0},
		'{"burst4_lat7", 7, 4, 2, 1'b0},
		'{"seq_flush", 4, 3, 0, 1'b1}
	};

	logic                      pll_afi_clk;
	logic                      reset_n_afi_clk;
	afi_read_req_t             req;
	ddio_capture_t             cap;
	lat_cnt_t                  lat;
	logic [`RD_NUM_GROUPS-1:0] fifo_rst;
	afi_rdata_t                afi_rdata;
	seq_rdata_t                seq_rdata;
	logic [`RD_RATE_RATIO-1:0] rdata_valid;
	logic                      oct_off;

	// Reference model state, indexed by the count of edges since reset release
	bit          en_rec [MAX_EDGES];
	bit          full_rec [MAX_EDGES];
	int          lat_rec [MAX_EDGES];
	int          edge_cnt = 0;
	logic [31:0] ref_q [`RD_NUM_GROUPS][$];
	logic [31:0] exp_word [`RD_NUM_GROUPS];
	bit          exp_valid = 1'b0;
	bit          exp_oct = 1'b0;
	bit          started = 1'b0;
	string       cur_name = "reset";
	int          cyc_cnt = 0;
	int          cyc_limit = 0;
	logic [31:0] seed = 32'hcdac555d;

	read_datapath_top dut (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_read_req_i             (req),
		.ddio_capture_i             (cap),
		.seq_read_latency_counter_i (lat),
		.seq_read_fifo_reset_i      (fifo_rst),
		.afi_rdata_o                (afi_rdata),
		.phy_mux_read_fifo_q_o      (seq_rdata),
		.afi_rdata_valid_o          (rdata_valid),
		.force_oct_off_o            (oct_off)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #2 pll_afi_clk = ~pll_afi_clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Edges before reset release count as no request
	function automatic bit rec_bit(input bit full, input int idx);
		if (idx < 1 || idx >= MAX_EDGES)
			return 1'b0;
		return full ? full_rec[idx] : en_rec[idx];
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// **************************************************
	// Compare tasks
	// **************************************************
	task automatic check_afi(input afi_rdata_t exp, input afi_rdata_t act);
		if (act !== exp)
			stop_run($sformatf("Fail %s afi_rdata expected %h actual %h", cur_name, exp, act));
	endtask

	task automatic check_seq(input seq_rdata_t exp, input seq_rdata_t act);
		if (act !== exp)
			stop_run($sformatf("Fail %s seq_rdata expected %h actual %h", cur_name, exp, act));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("Fail %s %s expected %b actual %b", cur_name, what, exp, act));
	endtask

	// **************************************************
	// Reference model, runs on the sampled inputs of each edge
	// **************************************************
	always @(posedge pll_afi_clk)
	begin : model
		int e;
		started = 1'b1;
		if (reset_n_afi_clk && edge_cnt < MAX_EDGES - 1)
		begin
			edge_cnt = edge_cnt + 1;
			e = edge_cnt;
			en_rec[e] = req.rdata_en[0];
			full_rec[e] = req.rdata_en_full[0];
			lat_rec[e] = int'(lat);
			// Valid leaves the merge one edge after the latency tap fires
			exp_valid = (e > 1) ? rec_bit(1'b0, e - 1 - lat_rec[e-1]) : 1'b0;
			if (exp_valid)
			begin
				for (int g = 0; g < `RD_NUM_GROUPS; g++)
				begin
					if (ref_q[g].size() == 0)
						stop_run($sformatf("Read valid in %s with no captured word", cur_name));
					else
						exp_word[g] = ref_q[g].pop_front();
				end
			end
			// OCT stays on while any full request sits in the window taps
			exp_oct = 1'b1;
			for (int k = `RD_OCT_ON_DELAY; k <= `RD_OCT_OFF_DELAY; k++)
			begin
				if (rec_bit(1'b1, e - k))
					exp_oct = 1'b0;
			end
			for (int g = 0; g < `RD_NUM_GROUPS; g++)
			begin
				if (fifo_rst[g])
					ref_q[g].delete();
				else if (cap.strobe[g])
					ref_q[g].push_back(cap.word[g]);
			end
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge pll_afi_clk)
	begin : monitor
		logic [$bits(afi_rdata_t)-1:0] afi_flat;
		logic [$bits(seq_rdata_t)-1:0] seq_flat;
		logic [7:0]                    beat;
		if (started)
		begin
			for (int p = 0; p < `RD_RATE_RATIO; p++)
				check_bit("afi_rdata_valid", exp_valid, rdata_valid[p]);
			check_bit("force_oct_off", exp_oct, oct_off);
			if (exp_valid)
			begin
				// AFI bus is slot major, sequencer bus is group major
				for (int g = 0; g < `RD_NUM_GROUPS; g++)
				begin
					for (int t = 0; t < `RD_TIMESLOTS; t++)
					begin
						beat = exp_word[g][8*t +: 8];
						afi_flat[8*(t*`RD_NUM_GROUPS + g) +: 8] = beat;
						seq_flat[8*(g*`RD_TIMESLOTS + t) +: 8] = beat;
					end
				end
				check_afi(afi_rdata_t'(afi_flat), afi_rdata);
				check_seq(seq_rdata_t'(seq_flat), seq_rdata);
			end
		end
	end

	always @(posedge pll_afi_clk)
	begin
		cyc_cnt++;
		if (cyc_limit > 0 && cyc_cnt > cyc_limit)
			stop_run($sformatf("Timeout after %0d cycles in %s", cyc_cnt, cur_name));
	end

	// **************************************************
	// Stimulus tasks
	// **************************************************
	task automatic capture_words(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge pll_afi_clk);
			for (int g = 0; g < `RD_NUM_GROUPS; g++)
			begin
				seed = xorshift(seed);
				cap.word[g] <= group_word_t'(seed);
			end
			cap.strobe <= '1;
		end
		@(posedge pll_afi_clk);
		cap.strobe <= '0;
	endtask

	task automatic issue_reads(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge pll_afi_clk);
			req <= '{rdata_en: '1, rdata_en_full: '1};
		end
		@(posedge pll_afi_clk);
		req <= '0;
	endtask

	task automatic flush_fifos();
		@(posedge pll_afi_clk);
		fifo_rst <= '1;
		@(posedge pll_afi_clk);
		@(posedge pll_afi_clk);
		fifo_rst <= '0;
	endtask

	initial
	begin
		reset_n_afi_clk = 1'b1;
		req = '0;
		cap = '0;
		lat = lat_cnt_t'(1);
		fifo_rst = '0;
		// Budget each case for its burst twice, its latency twice and some setup
		cyc_limit = 40;
		for (int i = 0; i < NUM_TESTS; i++)
			cyc_limit += 2 * tests[i].words + 2 * tests[i].lat + tests[i].delay + 20;
		#1 reset_n_afi_clk = 1'b0;
		repeat (4) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		repeat (3) @(posedge pll_afi_clk);

		for (int i = 0; i < NUM_TESTS; i++)
		begin
			cur_name = tests[i].name;
			@(posedge pll_afi_clk);
			lat <= lat_cnt_t'(tests[i].lat);
			repeat (2) @(posedge pll_afi_clk);
			if (tests[i].flush)
			begin
				// These words must never come back
				capture_words(3);
				flush_fifos();
			end
			capture_words(tests[i].words);
			repeat (tests[i].delay) @(posedge pll_afi_clk);
			issue_reads(tests[i].words);
			while (ref_q[0].size() != 0)
				@(posedge pll_afi_clk);
			repeat (tests[i].lat + 4) @(posedge pll_afi_clk);
		end

		cur_name = "end";
		repeat (4) @(posedge pll_afi_clk);
		if (dut.u_read_enable_timing.u_read_datapath_checker.fail_cnt == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
		begin
			$display("Result: FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* read_datapath_top.f */
+incdir+rtl
rtl/read_datapath_pkg.sv
rtl/read_enable_timing.sv
rtl/read_group_fifo.sv
rtl/read_result_merge.sv
rtl/read_datapath_top.sv
dv/read_datapath_checker.sv
dv/read_datapath_tb.sv

/* Makefile */
# Verilator build and run for the read datapath testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = read_datapath_tb
FILELIST = read_datapath_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
